// ==== run_sim.sh ====
#!/bin/sh
# Build with Verilator, run, and look for the pass line in the output
cd "$(dirname "$0")" &&
  verilator --binary --timing --assert -Wno-fatal --top-module video_tb \
    -f verilog.f -o video_sim &&
  ./obj_dir/video_sim | tee /dev/stderr | grep "All tests passed" > /dev/null &&
  echo "Simulation PASSED" ||
  { echo "Simulation FAILED"; exit 1; }

// ==== sim/tb_clock.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_clock #(
  parameter int half_period = 10
) (
  output logic clk
);

  initial clk = 1'b0;

  always #(half_period) clk = ~clk;  // 20 ns period

endmodule

`default_nettype wire

// ==== sim/video_asserts.sv ====
`timescale 1ns/1ps
`default_nettype none

module video_asserts (
  input wire       clk,
  input wire       reset,
  input wire       wb_cyc,
  input wire       wb_stb,
  input wire       wb_ack,
  input wire [1:0] mode,
  input wire       de,
  input wire       hsync
);

  // Ack answers a strobe seen on the previous edge
  ack_after_strobe: assert property (@(posedge clk) disable iff (reset)
    wb_ack |-> $past(wb_cyc && wb_stb))
    else $error("wb_ack raised without a strobe in the previous cycle");

  ack_one_cycle: assert property (@(posedge clk) disable iff (reset) wb_ack |=> !wb_ack)
    else $error("wb_ack held high for two cycles");

  de_outside_hsync: assert property (@(posedge clk) disable iff (reset) !(de && hsync))
    else $error("de and hsync high together");

  // Pipeline is flushed one cycle after the mode write
  de_off_in_mode0: assert property (@(posedge clk) disable iff (reset)
    mode == 2'd0 && $stable(mode) |-> !de)
    else $error("de high while video is off");

endmodule

bind video_top video_asserts bus_and_timing_checks (
  .clk, .reset, .wb_cyc, .wb_stb, .wb_ack, .mode, .de, .hsync
);

`default_nettype wire

// ==== sim/video_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module video_tb;
  import video_pkg::*;

  localparam int LINE_PIX = 640;
  localparam int LINE_CYCLES = 800;
  localparam int FRAME_CYCLES = LINE_CYCLES * 525;
  // Vertical test may wait most of a frame before it can measure one
  localparam int TIMEOUT_CYCLES = 2 * FRAME_CYCLES + 660_000;
  localparam int MAX_REPORTS = 20;
  localparam int PROBE_DE = 0;
  localparam int PROBE_HS = 1;
  localparam int PROBE_VS = 2;

  // DVI control symbols
  localparam logic [9:0] CODE_NONE = 10'b1101010100;
  localparam logic [9:0] CODE_HS   = 10'b0010101011;
  localparam logic [9:0] CODE_VS   = 10'b0101010100;
  localparam logic [9:0] CODE_BOTH = 10'b1010101011;

  logic        clk;
  logic        reset;
  logic        wb_cyc;
  logic        wb_stb;
  logic        wb_we;
  logic [1:0]  wb_adr;
  logic [31:0] wb_dat_w;
  logic [31:0] wb_dat_r;
  logic        wb_ack;
  logic [9:0]  tmds_red;
  logic [9:0]  tmds_green;
  logic [9:0]  tmds_blue;

  logic [31:0] lfsr = 32'h48f55fbc;
  logic [15:0] pixels [LINE_PIX];
  logic [9:0]  exp_red [LINE_PIX];
  logic [9:0]  exp_green [LINE_PIX];
  logic [9:0]  exp_blue [LINE_PIX];
  int          disparity [3];
  int          cycles;
  int          test_errors;
  int          tests_passed;
  int          tests_failed;
  string       test_name;

  tb_clock clock_i (.clk);

  video_top #(.line_words(512)) dut_i (
    .clk, .reset, .wb_cyc, .wb_stb, .wb_we, .wb_adr, .wb_dat_w, .wb_dat_r, .wb_ack,
    .tmds_red, .tmds_green, .tmds_blue
  );

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles >= TIMEOUT_CYCLES) begin
      $display("Timeout: run stopped after %0d cycles in test %s", cycles, test_name);
      $display("Some tests failed");
      $finish;
    end
  end

  function automatic logic [31:0] random_bits(input int n);
    logic [31:0] r;
    logic        b;
    r = '0;
    for (int i = 0; i < n; i++) begin
      b = lfsr[0];
      lfsr = lfsr >> 1;
      if (b) lfsr = lfsr ^ 32'h80200003;
      r = {r[30:0], b};
    end
    return r;
  endfunction

  // Reference 8b/10b data encoding, disparity kept per channel
  function automatic logic [9:0] encode_tmds(input logic [7:0] d, input int ch);
    logic [8:0] qm;
    logic       xnor_mode;
    int         diff;
    logic [9:0] sym;
    xnor_mode = $countones(d) > 4 || ($countones(d) == 4 && !d[0]);
    qm[0] = d[0];
    for (int i = 1; i < 8; i++) qm[i] = xnor_mode ? ~(qm[i-1] ^ d[i]) : qm[i-1] ^ d[i];
    qm[8] = !xnor_mode;
    diff = 2 * $countones(qm[7:0]) - 8;  // Ones minus zeros
    if (disparity[ch] == 0 || diff == 0) begin
      sym = {~qm[8], qm[8], qm[8] ? qm[7:0] : ~qm[7:0]};
      disparity[ch] += qm[8] ? diff : -diff;
    end else if ((disparity[ch] > 0) == (diff > 0)) begin
      sym = {1'b1, qm[8], ~qm[7:0]};
      disparity[ch] += 2 * int'(qm[8]) - diff;
    end else begin
      sym = {1'b0, qm[8], qm[7:0]};
      disparity[ch] += diff - 2 * int'(!qm[8]);
    end
    return sym;
  endfunction

  function automatic bit channel_flag(input int which);
    case (which)
      PROBE_DE: return tmds_green != CODE_NONE && tmds_green != CODE_HS &&
                       tmds_green != CODE_VS && tmds_green != CODE_BOTH;
      PROBE_HS: return tmds_blue == CODE_HS || tmds_blue == CODE_BOTH;
      default:  return tmds_blue == CODE_VS || tmds_blue == CODE_BOTH;
    endcase
  endfunction

  task automatic begin_test(input string name);
    test_name = name;
    test_errors = 0;
  endtask

  task automatic end_test();
    $display("%s: %0d errors", test_name, test_errors);
    if (test_errors == 0) tests_passed++;
    else tests_failed++;
  endtask

  task automatic compare(input string what, input logic [31:0] expected,
                         input logic [31:0] actual);
    assert (actual === expected) else begin
      test_errors++;
      if (test_errors <= MAX_REPORTS)
        $display("[ERROR] %s %s: expected %0h, actual %0h", test_name, what, expected, actual);
    end
  endtask

  task automatic wb_access(input bit we, input logic [1:0] adr, input logic [31:0] data,
                           output logic [31:0] rdata);
    int waited;
    @(posedge clk);
    wb_cyc <= 1'b1;
    wb_stb <= 1'b1;
    wb_we <= we;
    wb_adr <= adr;
    wb_dat_w <= data;
    waited = 0;
    do begin
      @(negedge clk);
      waited++;
    end while (!wb_ack && waited < 8);
    assert (wb_ack) else begin
      test_errors++;
      $display("%s: no ack from register %0d within 8 cycles", test_name, adr);
    end
    compare("ack cycles", 2, waited);  // Strobe cycle plus one
    rdata = wb_dat_r;
    @(posedge clk);
    wb_cyc <= 1'b0;
    wb_stb <= 1'b0;
    wb_we <= 1'b0;
  endtask

  task automatic wb_write(input logic [1:0] adr, input logic [31:0] data);
    logic [31:0] unused;
    wb_access(1'b1, adr, data, unused);
  endtask

  task automatic wb_read(input logic [1:0] adr, output logic [31:0] data);
    wb_access(1'b0, adr, 32'd0, data);
  endtask

  task automatic count_until(input int which, input bit level, output int n);
    n = 0;
    do begin
      @(negedge clk);
      n++;
    end while (channel_flag(which) != level);
  endtask

  task automatic check_idle();
    compare("red idle", CODE_NONE, tmds_red);
    compare("green idle", CODE_NONE, tmds_green);
    compare("blue idle", CODE_NONE, tmds_blue);
  endtask

  task automatic check_horizontal(input int exp_data, exp_gap, exp_hs, exp_period);
    int n;
    int data_len;
    int gap_len;
    int hs_len;
    int rest;
    count_until(PROBE_DE, 0, n);
    count_until(PROBE_DE, 1, n);
    count_until(PROBE_DE, 0, data_len);
    count_until(PROBE_HS, 1, gap_len);
    count_until(PROBE_HS, 0, hs_len);
    count_until(PROBE_DE, 1, rest);
    compare("data symbols", exp_data, data_len);
    compare("gap before hsync", exp_gap, gap_len);
    compare("hsync width", exp_hs, hs_len);
    compare("line period", exp_period, data_len + gap_len + hs_len + rest);
  endtask

  task automatic load_line();
    wb_write(REG_PTR, 32'd0);
    for (int w = 0; w < LINE_PIX / 4; w++) begin
      wb_write(REG_DATA_LO, {pixels[4*w+1], pixels[4*w]});
      wb_write(REG_DATA_HI, {pixels[4*w+3], pixels[4*w+2]});
    end
  endtask

  task automatic build_expected(input bit show, input bit alpha_fmt);
    pixel16_u   p;
    logic [7:0] r;
    logic [7:0] g;
    logic [7:0] b;
    disparity = '{0, 0, 0};  // Fresh after each blanking period
    for (int i = 0; i < LINE_PIX; i++) begin
      p = pixels[i];
      r = {p.rgb565.red, p.rgb565.red[4:2]};
      b = {p.rgb565.blue, p.rgb565.blue[4:2]};
      if (alpha_fmt) g = {p.rgb555a.green, p.rgb555a.green[4:2]};
      else g = {p.rgb565.green, p.rgb565.green[5:4]};
      if (!show || (alpha_fmt && p.rgb555a.alpha)) {r, g, b} = 24'd0;
      exp_red[i] = encode_tmds(r, 0);
      exp_green[i] = encode_tmds(g, 1);
      exp_blue[i] = encode_tmds(b, 2);
    end
  endtask

  task automatic compare_lines(input int lines);
    int n;
    for (int l = 0; l < lines; l++) begin
      count_until(PROBE_DE, 0, n);
      count_until(PROBE_DE, 1, n);
      for (int i = 0; i < LINE_PIX; i++) begin
        if (i > 0) @(negedge clk);
        compare("red symbol", exp_red[i], tmds_red);
        compare("green symbol", exp_green[i], tmds_green);
        compare("blue symbol", exp_blue[i], tmds_blue);
      end
    end
  endtask

  task automatic test_reset_and_regs();
    logic [31:0] rd;
    begin_test("reset_and_regs");
    repeat (2) @(posedge clk);  // Encoder pipeline fills
    repeat (16) begin
      @(negedge clk);
      check_idle();
    end
    wb_write(REG_CTRL, 32'hc);  // Mode stays off
    wb_read(REG_CTRL, rd);
    compare("ctrl readback", 32'hc, rd);
    wb_write(REG_PTR, 32'd37);
    wb_read(REG_PTR, rd);
    compare("ptr readback", 32'd37, rd);
    wb_write(REG_DATA_LO, 32'h12345678);
    wb_write(REG_DATA_HI, 32'h9abcdef0);
    wb_read(REG_PTR, rd);
    compare("ptr after word", 32'd38, rd);
    wb_read(REG_DATA_HI, rd);
    compare("data readback", 32'd0, rd);
    @(negedge clk);
    check_idle();
    end_test();
  endtask

  task automatic test_mode1_horizontal();
    begin_test("mode1_horizontal");
    wb_write(REG_CTRL, 32'h5);
    check_horizontal(640, 16, 96, 800);
    end_test();
  endtask

  task automatic test_mode1_vertical();
    int  n;
    int  vs_len;
    int  total;
    int  data_lines;
    bit  prev_de;
    begin_test("mode1_vertical");
    wb_write(REG_CTRL, 32'h5);
    count_until(PROBE_VS, 1, n);
    count_until(PROBE_VS, 0, vs_len);
    total = vs_len;
    data_lines = 0;
    prev_de = 1'b0;
    do begin
      @(negedge clk);
      total++;
      if (channel_flag(PROBE_DE) && !prev_de) data_lines++;
      prev_de = channel_flag(PROBE_DE);
    end while (!channel_flag(PROBE_VS));
    compare("vsync lines", 2, vs_len / LINE_CYCLES);
    compare("frame lines", 525, total / LINE_CYCLES);
    compare("frame cycles", FRAME_CYCLES, total);
    compare("data lines", 480, data_lines);
    end_test();
  endtask

  task automatic test_rgb565_content();
    begin_test("rgb565_content");
    for (int i = 0; i < LINE_PIX; i++) pixels[i] = 16'(random_bits(16));
    load_line();
    build_expected(1'b1, 1'b0);
    wb_write(REG_CTRL, 32'h5);
    compare_lines(480);
    end_test();
  endtask

  task automatic test_alpha_and_blank();
    begin_test("alpha_and_blank");
    build_expected(1'b1, 1'b1);
    wb_write(REG_CTRL, 32'hd);
    compare_lines(2);
    build_expected(1'b0, 1'b0);
    wb_write(REG_CTRL, 32'h1);  // Graphics off
    compare_lines(2);
    end_test();
  endtask

  task automatic test_mode3_horizontal();
    begin_test("mode3_horizontal");
    wb_write(REG_CTRL, 32'h7);
    check_horizontal(1280, 110, 40, 1650);
    end_test();
  endtask

  initial begin
    reset = 1'b1;
    wb_cyc = 1'b0;
    wb_stb = 1'b0;
    wb_we = 1'b0;
    wb_adr = 2'd0;
    wb_dat_w = 32'd0;
    test_name = "reset";
    repeat (2) @(posedge clk);
    reset <= 1'b0;
    test_reset_and_regs();
    test_mode1_horizontal();
    test_mode1_vertical();
    test_rgb565_content();
    test_alpha_and_blank();
    test_mode3_horizontal();
    $display("Tests passed: %0d, failed: %0d", tests_passed, tests_failed);
    if (tests_failed == 0) begin
      $display("All tests passed");
    end else begin
      $display("Some tests failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== source/line_buffer.sv ====
`timescale 1ns/1ps
`default_nettype none

module line_buffer #(
  parameter int line_words = 512
) (
  input  wire                             clk,
  input  wire                             we,
  input  wire  [$clog2(line_words)-1:0]   waddr,
  input  wire  [63:0]                     wdata,
  input  wire  [video_pkg::H_W-3:0]       raddr,
  output logic [63:0]                     rdata
);

  // Four 16-bit pixels per word
  logic [63:0] mem [line_words];

  always_ff @(posedge clk) begin
    if (we) begin
      mem[waddr] <= wdata;
    end
  end

  // Registered read with one cycle latency
  always_ff @(posedge clk) begin
    rdata <= mem[raddr];
  end

endmodule

`default_nettype wire

// ==== source/pixel_unpack.sv ====
`timescale 1ns/1ps
`default_nettype none

module pixel_unpack (
  input  wire        clk,
  input  wire [63:0] rd_word,
  input  wire [1:0]  pix_sel,
  input  wire        show_graphic,
  input  wire        use_alpha,
  output logic [7:0] red,
  output logic [7:0] green,
  output logic [7:0] blue
);
  import video_pkg::*;

  pixel16_u    pix;
  logic [7:0]  red_x;
  logic [7:0]  green_x;
  logic [7:0]  blue_x;
  logic        blank;
  logic [23:0] rgb_q;

  // Pixel 0 sits in the low half-word
  assign pix = rd_word[16*pix_sel +: 16];

  assign red_x  = {pix.rgb565.red, pix.rgb565.red[4:2]};
  assign blue_x = {pix.rgb565.blue, pix.rgb565.blue[4:2]};

  // Alpha format gives up one green bit for the flag
  assign green_x = use_alpha ? {pix.rgb555a.green, pix.rgb555a.green[4:2]}
                             : {pix.rgb565.green, pix.rgb565.green[5:4]};

  assign blank = !show_graphic || (use_alpha && pix.rgb555a.alpha);

  always_ff @(posedge clk) begin
    rgb_q <= blank ? 24'd0 : {red_x, green_x, blue_x};
    {red, green, blue} <= rgb_q;  // Output register
  end

endmodule

`default_nettype wire

// ==== source/tmds_encoder.sv ====
`timescale 1ns/1ps
`default_nettype none

module tmds_encoder (
  input  wire        clk,
  input  wire  [7:0] data,
  input  wire  [1:0] ctl,
  input  wire        de,
  output logic [9:0] symbol
);
  import video_pkg::*;

  logic [3:0] n1_data;
  logic       use_xnor;
  logic [8:0] q_m;
  logic [8:0] q_m_q;
  logic [1:0] ctl_q;
  logic       de_q;
  logic [3:0] bal;       // Half of ones minus zeros in two's complement
  logic [3:0] disp;      // Running disparity in the same units
  logic [3:0] disp_next;
  logic [9:0] data_sym;

  assign n1_data  = 4'($countones(data));
  assign use_xnor = n1_data > 4'd4 || (n1_data == 4'd4 && !data[0]);

  // Transition minimizing stage
  always_comb begin
    q_m[0] = data[0];
    for (int i = 1; i < 8; i++) begin
      q_m[i] = q_m[i-1] ^ data[i] ^ use_xnor;
    end
    q_m[8] = !use_xnor;
  end

  always_ff @(posedge clk) begin
    q_m_q <= q_m;
    ctl_q <= ctl;
    de_q  <= de;
  end

  assign bal = 4'($countones(q_m_q[7:0])) - 4'd4;

  always_comb begin
    if (disp == 4'd0 || bal == 4'd0) begin
      data_sym  = {~q_m_q[8], q_m_q[8], q_m_q[8] ? q_m_q[7:0] : ~q_m_q[7:0]};
      disp_next = q_m_q[8] ? disp + bal : disp - bal;
    end else if (disp[3] == bal[3]) begin
      // Same sign so invert to pull back toward zero
      data_sym  = {1'b1, q_m_q[8], ~q_m_q[7:0]};
      disp_next = disp + {3'b000, q_m_q[8]} - bal;
    end else begin
      data_sym  = {1'b0, q_m_q[8], q_m_q[7:0]};
      disp_next = disp - {3'b000, ~q_m_q[8]} + bal;
    end
  end

  always_ff @(posedge clk) begin
    symbol <= de_q ? data_sym : CTL_CODES[ctl_q];
    disp   <= de_q ? disp_next : 4'd0;  // Blanking restarts the balance
  end

endmodule

`default_nettype wire

// ==== source/video_pkg.sv ====
`default_nettype none

package video_pkg;

  localparam int WB_DATA_W = 32;
  localparam int WB_ADDR_W = 2;

  // Register word addresses
  localparam logic [WB_ADDR_W-1:0] REG_CTRL    = 2'd0;
  localparam logic [WB_ADDR_W-1:0] REG_PTR     = 2'd1;
  localparam logic [WB_ADDR_W-1:0] REG_DATA_LO = 2'd2;
  localparam logic [WB_ADDR_W-1:0] REG_DATA_HI = 2'd3;

  // Buffer read, unpack register, output register
  localparam int PIX_DELAY = 3;

  localparam int H_W = 11;
  localparam int V_W = 10;

  // Mode tables indexed by video mode with entry 0 for video off
  localparam logic [3:0][H_W-1:0] H_DRAW_END   = {11'd1280, 11'd1024, 11'd640, 11'd0};
  localparam logic [3:0][H_W-1:0] H_SYNC_START = {11'd1390, 11'd1048, 11'd656, 11'd0};
  localparam logic [3:0][H_W-1:0] H_SYNC_END   = {11'd1430, 11'd1184, 11'd752, 11'd0};
  localparam logic [3:0][H_W-1:0] H_LAST       = {11'd1649, 11'd1343, 11'd799, 11'd0};
  localparam logic [3:0][V_W-1:0] V_DRAW_END   = {10'd720, 10'd768, 10'd480, 10'd0};
  localparam logic [3:0][V_W-1:0] V_SYNC_START = {10'd725, 10'd771, 10'd490, 10'd0};
  localparam logic [3:0][V_W-1:0] V_SYNC_END   = {10'd730, 10'd777, 10'd492, 10'd0};
  localparam logic [3:0][V_W-1:0] V_LAST       = {10'd749, 10'd805, 10'd524, 10'd0};

  // Indexed by {vsync, hsync}
  localparam logic [3:0][9:0] CTL_CODES = {
    10'b1010101011,
    10'b0101010100,
    10'b0010101011,
    10'b1101010100
  };

  typedef struct packed {
    logic [4:0] red;
    logic [5:0] green;
    logic [4:0] blue;
  } rgb565_t;

  typedef struct packed {
    logic [4:0] red;
    logic [4:0] green;
    logic       alpha;
    logic [4:0] blue;
  } rgb555a_t;

  typedef union packed {
    rgb565_t  rgb565;
    rgb555a_t rgb555a;
  } pixel16_u;

endpackage

`default_nettype wire

// ==== source/video_regs.sv ====
`timescale 1ns/1ps
`default_nettype none

module video_regs #(
  parameter int line_words = 512
) (
  input  wire                                  clk,
  input  wire                                  reset,
  input  wire                                  wb_cyc,
  input  wire                                  wb_stb,
  input  wire                                  wb_we,
  input  wire  [video_pkg::WB_ADDR_W-1:0]      wb_adr,
  input  wire  [video_pkg::WB_DATA_W-1:0]      wb_dat_w,
  output logic [video_pkg::WB_DATA_W-1:0]      wb_dat_r,
  output logic                                 wb_ack,
  output logic [1:0]                           mode,
  output logic                                 show_graphic,
  output logic                                 use_alpha,
  output logic                                 ctrl_write,
  output logic                                 buf_we,
  output logic [$clog2(line_words)-1:0]        buf_waddr,
  output logic [63:0]                          buf_wdata
);
  import video_pkg::*;

  localparam int AW = $clog2(line_words);

  logic                 req;
  logic                 wr_req;
  logic [AW-1:0]        ptr;
  logic [AW-1:0]        ptr_next;
  logic [WB_DATA_W-1:0] data_lo;
  logic [WB_DATA_W-1:0] rd_data;

  // The ack cycle itself is not a new request
  assign req    = wb_cyc && wb_stb && !wb_ack;
  assign wr_req = req && wb_we;

  assign ptr_next = (ptr == AW'(line_words - 1)) ? '0 : ptr + 1'b1;  // Wrap at buffer end

  always_comb begin
    case (wb_adr)
      REG_CTRL: rd_data = WB_DATA_W'({use_alpha, show_graphic, mode});
      REG_PTR:  rd_data = WB_DATA_W'(ptr);
      default:  rd_data = '0;
    endcase
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      wb_ack       <= 1'b0;
      ctrl_write   <= 1'b0;
      buf_we       <= 1'b0;
      mode         <= 2'd0;
      show_graphic <= 1'b0;
      use_alpha    <= 1'b0;
      ptr          <= '0;
    end else begin
      wb_ack     <= req;
      ctrl_write <= wr_req && wb_adr == REG_CTRL;
      buf_we     <= wr_req && wb_adr == REG_DATA_HI;
      if (wr_req) begin
        case (wb_adr)
          REG_CTRL:    {use_alpha, show_graphic, mode} <= wb_dat_w[3:0];
          REG_PTR:     ptr <= wb_dat_w[AW-1:0];
          REG_DATA_HI: ptr <= ptr_next;
          default:     ;
        endcase
      end
    end
  end

  always_ff @(posedge clk) begin
    if (req) begin
      wb_dat_r <= rd_data;
    end
    if (wr_req && wb_adr == REG_DATA_LO) begin
      data_lo <= wb_dat_w;
    end
    // High half completes the word
    if (wr_req && wb_adr == REG_DATA_HI) begin
      buf_waddr <= ptr;
      buf_wdata <= {wb_dat_w, data_lo};
    end
  end

endmodule

`default_nettype wire

// ==== source/video_timing.sv ====
`timescale 1ns/1ps
`default_nettype none

module video_timing (
  input  wire                         clk,
  input  wire                         reset,
  input  wire  [1:0]                  mode,
  input  wire                         ctrl_write,
  output logic [video_pkg::H_W-3:0]   rd_addr,
  output logic [1:0]                  pix_sel,
  output logic                        de,
  output logic                        hsync,
  output logic                        vsync
);
  import video_pkg::*;

  logic [H_W-1:0] h_count;
  logic [V_W-1:0] v_count;
  logic [H_W-1:0] h_draw_end;
  logic [H_W-1:0] h_sync_start;
  logic [H_W-1:0] h_sync_end;
  logic [H_W-1:0] h_last;
  logic [V_W-1:0] v_draw_end;
  logic [V_W-1:0] v_sync_start;
  logic [V_W-1:0] v_sync_end;
  logic [V_W-1:0] v_last;
  logic           active;
  logic           draw;
  logic           hs;
  logic           vs;

  // {draw, hsync, vsync} per stage
  logic [PIX_DELAY-1:0][2:0] flag_pipe;

  assign h_draw_end   = H_DRAW_END[mode];
  assign h_sync_start = H_SYNC_START[mode];
  assign h_sync_end   = H_SYNC_END[mode];
  assign h_last       = H_LAST[mode];
  assign v_draw_end   = V_DRAW_END[mode];
  assign v_sync_start = V_SYNC_START[mode];
  assign v_sync_end   = V_SYNC_END[mode];
  assign v_last       = V_LAST[mode];

  assign active = mode != 2'd0;

  always_ff @(posedge clk) begin
    if (reset || ctrl_write || !active) begin
      h_count <= '0;
      v_count <= '0;
    end else if (h_count == h_last) begin
      h_count <= '0;
      v_count <= (v_count == v_last) ? '0 : v_count + 1'b1;
    end else begin
      h_count <= h_count + 1'b1;
    end
  end

  assign draw = active && h_count < h_draw_end && v_count < v_draw_end;
  assign hs   = active && h_count >= h_sync_start && h_count < h_sync_end;
  assign vs   = active && v_count >= v_sync_start && v_count < v_sync_end;

  // Align flags with pixel data at the encoder inputs
  always_ff @(posedge clk) begin
    if (reset || ctrl_write) begin
      flag_pipe <= '0;
    end else begin
      flag_pipe <= {flag_pipe[PIX_DELAY-2:0], {draw, hs, vs}};
    end
  end

  assign {de, hsync, vsync} = flag_pipe[PIX_DELAY-1];

  assign rd_addr = h_count[H_W-1:2];

  always_ff @(posedge clk) begin
    pix_sel <= h_count[1:0];  // Matches buffer read latency
  end

endmodule

`default_nettype wire

// ==== source/video_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module video_top #(
  parameter int line_words = 512
) (
  input  wire                              clk,
  input  wire                              reset,
  input  wire                              wb_cyc,
  input  wire                              wb_stb,
  input  wire                              wb_we,
  input  wire [video_pkg::WB_ADDR_W-1:0]   wb_adr,
  input  wire [video_pkg::WB_DATA_W-1:0]   wb_dat_w,
  output wire [video_pkg::WB_DATA_W-1:0]   wb_dat_r,
  output wire                              wb_ack,
  output wire [9:0]                        tmds_red,
  output wire [9:0]                        tmds_green,
  output wire [9:0]                        tmds_blue
);
  import video_pkg::*;

  localparam int AW = $clog2(line_words);

  logic [1:0]     mode;
  logic           show_graphic;
  logic           use_alpha;
  logic           ctrl_write;
  logic           buf_we;
  logic [AW-1:0]  buf_waddr;
  logic [63:0]    buf_wdata;
  logic [H_W-3:0] rd_addr;
  logic [63:0]    rd_word;
  logic [1:0]     pix_sel;
  logic           de;
  logic           hsync;
  logic           vsync;
  logic [7:0]     red;
  logic [7:0]     green;
  logic [7:0]     blue;
  logic [1:0]     ctl_none;

  assign ctl_none = 2'b00;  // Sync rides on blue only

  video_regs #(.line_words(line_words)) u_regs (
    .clk, .reset,
    .wb_cyc, .wb_stb, .wb_we, .wb_adr, .wb_dat_w, .wb_dat_r, .wb_ack,
    .mode, .show_graphic, .use_alpha, .ctrl_write,
    .buf_we, .buf_waddr, .buf_wdata
  );

  line_buffer #(.line_words(line_words)) u_buf (
    .clk,
    .we(buf_we), .waddr(buf_waddr), .wdata(buf_wdata),
    .raddr(rd_addr), .rdata(rd_word)
  );

  video_timing u_timing (
    .clk, .reset, .mode, .ctrl_write,
    .rd_addr, .pix_sel, .de, .hsync, .vsync
  );

  pixel_unpack u_unpack (
    .clk, .rd_word, .pix_sel, .show_graphic, .use_alpha,
    .red, .green, .blue
  );

  tmds_encoder u_enc_red (.clk, .data(red), .ctl(ctl_none), .de, .symbol(tmds_red));

  tmds_encoder u_enc_green (.clk, .data(green), .ctl(ctl_none), .de, .symbol(tmds_green));

  tmds_encoder u_enc_blue (.clk, .data(blue), .ctl({vsync, hsync}), .de, .symbol(tmds_blue));

endmodule

`default_nettype wire

// ==== verilog.f ====
source/video_pkg.sv
source/video_regs.sv
source/line_buffer.sv
source/video_timing.sv
source/pixel_unpack.sv
source/tmds_encoder.sv
source/video_top.sv
sim/tb_clock.sv
sim/video_asserts.sv
sim/video_tb.sv
